//--- design/host_domain_pkg.sv
//####################
// Host domain package
// Address map, host bus types and L2 word address layout
//####################

package host_domain_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // L2 geometry
  localparam int unsigned NbL2Banks       = 8;
  localparam int unsigned L2BankSize      = 1024;
  localparam int unsigned L2BankAddrWidth = 10;
  localparam int unsigned L2BankSelWidth  = 3;

  // Address map
  localparam logic [AddrWidth-1:0] L2Base  = 32'h1C00_0000;
  localparam logic [AddrWidth-1:0] L2Size  = 32'h0000_8000;
  localparam logic [AddrWidth-1:0] CfgBase = 32'h1000_0000;
  localparam logic [AddrWidth-1:0] CfgSize = 32'h0000_1000;
  localparam logic [DataWidth-1:0] ErrData = 32'hDEAD_F000;

  // Register offsets inside the config block
  localparam logic [AddrWidth-1:0] RegCacheStart = 32'h00;
  localparam logic [AddrWidth-1:0] RegCacheEnd   = 32'h04;
  localparam logic [AddrWidth-1:0] RegCachedRd   = 32'h08;
  localparam logic [AddrWidth-1:0] RegCachedWr   = 32'h0C;
  localparam logic [AddrWidth-1:0] RegUncachedRd = 32'h10;
  localparam logic [AddrWidth-1:0] RegUncachedWr = 32'h14;
  localparam logic [AddrWidth-1:0] RegDmaEvt     = 32'h18;
  localparam logic [AddrWidth-1:0] RegDoorbell   = 32'h1C;
  localparam logic [AddrWidth-1:0] RegCompletion = 32'h20;

  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } host_req_t;

  typedef struct packed {
    logic                 rvalid;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } host_rsp_t;

  // One-cycle pulses, one per classified L2 access
  typedef struct packed {
    logic cached_rd;
    logic cached_wr;
    logic uncached_rd;
    logic uncached_wr;
  } llc_evt_t;

  // Word index, low bits pick the bank
  typedef union packed {
    logic [L2BankAddrWidth+L2BankSelWidth-1:0] flat;
    struct packed {
      logic [L2BankAddrWidth-1:0] row;
      logic [L2BankSelWidth-1:0]  bank;
    } banked;
  } l2_addr_u;

endpackage

//--- design/edge_propagator_rx.sv
//####################
// Edge propagator receiver
// Syncs a toggling level, pulses once per toggle
//####################

`timescale 1ns/100ps

module edge_propagator_rx (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic valid_o,
  output logic ack_o
);

  logic [1:0] sync_q;
  logic       hist_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q <= 2'b00;
      hist_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], valid_i};
      hist_q <= sync_q[1];
    end
  end

  // Sender sees its own level echoed back
  assign ack_o   = sync_q[1];
  assign valid_o = sync_q[1] ^ hist_q;

endmodule

//--- design/l2_bank_mem.sv
//####################
// L2 banked memory
// Word-interleaved banks with one registered read port
//####################

`timescale 1ns/100ps

module l2_bank_mem (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  host_domain_pkg::host_req_t            req_i,
  output logic [host_domain_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned ByteOffWidth = $clog2(host_domain_pkg::DataWidth / 8);

  host_domain_pkg::l2_addr_u             l2_addr;
  logic [host_domain_pkg::DataWidth-1:0] bank_rdata [host_domain_pkg::NbL2Banks];
  logic [host_domain_pkg::DataWidth-1:0] rdata_q;

  // Drop byte offset, L2 is aligned to its size
  assign l2_addr.flat = req_i.addr[ByteOffWidth +: $bits(l2_addr)];

  for (genvar b = 0; b < host_domain_pkg::NbL2Banks; b++) begin : gen_bank
    logic [host_domain_pkg::DataWidth-1:0] mem_q [host_domain_pkg::L2BankSize];
    logic                                  bank_we;

    assign bank_we = req_i.req && req_i.we && (l2_addr.banked.bank == b);

    always_ff @(posedge clk_i) begin
      if (bank_we) begin
        mem_q[l2_addr.banked.row] <= req_i.wdata;
      end
    end

    assign bank_rdata[b] = mem_q[l2_addr.banked.row];
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) begin
      rdata_q <= bank_rdata[l2_addr.banked.bank];
    end
  end

  assign rdata_o = rdata_q;

  // Decoder must only forward L2 addresses
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.req |-> (req_i.addr >= host_domain_pkg::L2Base) &&
                  (req_i.addr < host_domain_pkg::L2Base + host_domain_pkg::L2Size));

endmodule

//--- design/cfg_regs.sv
//####################
// Config register block
// Cache window, access and DMA event counters, interrupts
//####################

`timescale 1ns/100ps

module cfg_regs #(
  parameter int unsigned CntWidth = 32
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  host_domain_pkg::host_req_t            req_i,
  output logic [host_domain_pkg::DataWidth-1:0] rdata_o,
  input  host_domain_pkg::llc_evt_t             llc_evt_i,
  input  logic                                  dma_evt_i,
  output logic [host_domain_pkg::DataWidth-1:0] cache_start_o,
  output logic [host_domain_pkg::DataWidth-1:0] cache_end_o,
  output logic                                  doorbell_irq_o,
  output logic                                  completion_irq_o
);

  localparam int unsigned NbCnt = 5;

  logic [host_domain_pkg::AddrWidth-1:0] offset;
  logic                                  wr, rd;
  logic [host_domain_pkg::DataWidth-1:0] cache_start_q, cache_end_q;
  logic [host_domain_pkg::DataWidth-1:0] rdata_d, rdata_q;
  logic                                  doorbell_q, completion_q;
  logic [NbCnt-1:0]                      cnt_inc, cnt_clr;
  logic [CntWidth-1:0]                   cnt_q [NbCnt];

  assign offset = req_i.addr & (host_domain_pkg::CfgSize - 1);
  assign wr     = req_i.req && req_i.we;
  assign rd     = req_i.req && !req_i.we;

  // Counter order matches the register map
  assign cnt_inc = {dma_evt_i, llc_evt_i.uncached_wr, llc_evt_i.uncached_rd,
                    llc_evt_i.cached_wr, llc_evt_i.cached_rd};

  always_comb begin
    cnt_clr = '0;
    if (wr) begin
      case (offset)
        host_domain_pkg::RegCachedRd:   cnt_clr[0] = 1'b1;
        host_domain_pkg::RegCachedWr:   cnt_clr[1] = 1'b1;
        host_domain_pkg::RegUncachedRd: cnt_clr[2] = 1'b1;
        host_domain_pkg::RegUncachedWr: cnt_clr[3] = 1'b1;
        host_domain_pkg::RegDmaEvt:     cnt_clr[4] = 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '{default: '0};
    end else begin
      for (int i = 0; i < NbCnt; i++) begin
        if (cnt_clr[i]) begin
          cnt_q[i] <= '0;
        end else if (cnt_inc[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cache_start_q <= '0;
      cache_end_q   <= '0;
      doorbell_q    <= 1'b0;
      completion_q  <= 1'b0;
    end else if (wr) begin
      case (offset)
        host_domain_pkg::RegCacheStart: cache_start_q <= req_i.wdata;
        host_domain_pkg::RegCacheEnd:   cache_end_q   <= req_i.wdata;
        host_domain_pkg::RegDoorbell:   doorbell_q    <= req_i.wdata[0];
        host_domain_pkg::RegCompletion: completion_q  <= req_i.wdata[0];
        default: ;
      endcase
    end
  end

  // Unknown offsets read zero
  always_comb begin
    rdata_d = '0;
    case (offset)
      host_domain_pkg::RegCacheStart: rdata_d = cache_start_q;
      host_domain_pkg::RegCacheEnd:   rdata_d = cache_end_q;
      host_domain_pkg::RegCachedRd:   rdata_d[CntWidth-1:0] = cnt_q[0];
      host_domain_pkg::RegCachedWr:   rdata_d[CntWidth-1:0] = cnt_q[1];
      host_domain_pkg::RegUncachedRd: rdata_d[CntWidth-1:0] = cnt_q[2];
      host_domain_pkg::RegUncachedWr: rdata_d[CntWidth-1:0] = cnt_q[3];
      host_domain_pkg::RegDmaEvt:     rdata_d[CntWidth-1:0] = cnt_q[4];
      host_domain_pkg::RegDoorbell:   rdata_d[0] = doorbell_q;
      host_domain_pkg::RegCompletion: rdata_d[0] = completion_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o          = rdata_q;
  assign cache_start_o    = cache_start_q;
  assign cache_end_o      = cache_end_q;
  assign doorbell_irq_o   = doorbell_q;
  assign completion_irq_o = completion_q;

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wr && offset == host_domain_pkg::RegDoorbell) |=> $stable(doorbell_irq_o));

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wr && offset == host_domain_pkg::RegCompletion) |=> $stable(completion_irq_o));

endmodule

//--- design/host_bus_decode.sv
//####################
// Host bus decoder
// Routes requests, classifies L2 accesses, muxes responses
//####################

`timescale 1ns/100ps

module host_bus_decode (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  host_domain_pkg::host_req_t            host_req_i,
  output host_domain_pkg::host_rsp_t            host_rsp_o,
  input  logic [host_domain_pkg::DataWidth-1:0] cache_start_i,
  input  logic [host_domain_pkg::DataWidth-1:0] cache_end_i,
  output host_domain_pkg::host_req_t            l2_req_o,
  output host_domain_pkg::host_req_t            cfg_req_o,
  input  logic [host_domain_pkg::DataWidth-1:0] l2_rdata_i,
  input  logic [host_domain_pkg::DataWidth-1:0] cfg_rdata_i,
  output host_domain_pkg::llc_evt_t             llc_evt_o
);

  logic sel_l2, sel_cfg, sel_err, cached;
  logic rvalid_q, we_q, sel_l2_q, sel_cfg_q, sel_err_q;

  assign sel_l2 = host_req_i.req &&
                  (host_req_i.addr >= host_domain_pkg::L2Base) &&
                  (host_req_i.addr < host_domain_pkg::L2Base + host_domain_pkg::L2Size);
  assign sel_cfg = host_req_i.req &&
                   (host_req_i.addr >= host_domain_pkg::CfgBase) &&
                   (host_req_i.addr < host_domain_pkg::CfgBase + host_domain_pkg::CfgSize);
  assign sel_err = host_req_i.req && !sel_l2 && !sel_cfg;

  // Empty window when start equals end
  assign cached = (host_req_i.addr >= cache_start_i) && (host_req_i.addr < cache_end_i);

  always_comb begin
    l2_req_o      = host_req_i;
    l2_req_o.req  = sel_l2;
    cfg_req_o     = host_req_i;
    cfg_req_o.req = sel_cfg;
  end

  assign llc_evt_o.cached_rd   = sel_l2 &&  cached && !host_req_i.we;
  assign llc_evt_o.cached_wr   = sel_l2 &&  cached &&  host_req_i.we;
  assign llc_evt_o.uncached_rd = sel_l2 && !cached && !host_req_i.we;
  assign llc_evt_o.uncached_wr = sel_l2 && !cached &&  host_req_i.we;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q  <= 1'b0;
      we_q      <= 1'b0;
      sel_l2_q  <= 1'b0;
      sel_cfg_q <= 1'b0;
      sel_err_q <= 1'b0;
    end else begin
      rvalid_q  <= host_req_i.req;
      we_q      <= host_req_i.we;
      sel_l2_q  <= sel_l2;
      sel_cfg_q <= sel_cfg;
      sel_err_q <= sel_err;
    end
  end

  // Fixed one-cycle response, zero data after writes
  always_comb begin
    host_rsp_o.rvalid = rvalid_q;
    host_rsp_o.err    = sel_err_q;
    host_rsp_o.rdata  = '0;
    if (rvalid_q && !we_q) begin
      if (sel_l2_q) begin
        host_rsp_o.rdata = l2_rdata_i;
      end else if (sel_cfg_q) begin
        host_rsp_o.rdata = cfg_rdata_i;
      end else begin
        host_rsp_o.rdata = host_domain_pkg::ErrData;
      end
    end
  end

  // Each response is owned by exactly one target
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_req_i.req |=> $onehot({sel_l2_q, sel_cfg_q, sel_err_q}));

endmodule

//--- design/host_domain.sv
//####################
// Host domain top
// Host bus decode, L2 memory, config registers, DMA event sync
//####################

`timescale 1ns/100ps

module host_domain #(
  parameter int unsigned CntWidth = 32
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  host_domain_pkg::host_req_t host_req_i,
  output host_domain_pkg::host_rsp_t host_rsp_o,
  input  logic                       dma_pe_evt_valid_i,
  output logic                       dma_pe_evt_ack_o,
  output logic                       doorbell_irq_o,
  output logic                       completion_irq_o
);

  host_domain_pkg::host_req_t             l2_req;
  host_domain_pkg::host_req_t             cfg_req;
  host_domain_pkg::llc_evt_t              llc_evt;
  logic [host_domain_pkg::DataWidth-1:0]  l2_rdata;
  logic [host_domain_pkg::DataWidth-1:0]  cfg_rdata;
  logic [host_domain_pkg::DataWidth-1:0]  cache_start;
  logic [host_domain_pkg::DataWidth-1:0]  cache_end;
  logic                                   dma_evt;

  host_bus_decode i_host_bus_decode (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .host_req_i    ( host_req_i  ),
    .host_rsp_o    ( host_rsp_o  ),
    .cache_start_i ( cache_start ),
    .cache_end_i   ( cache_end   ),
    .l2_req_o      ( l2_req      ),
    .cfg_req_o     ( cfg_req     ),
    .l2_rdata_i    ( l2_rdata    ),
    .cfg_rdata_i   ( cfg_rdata   ),
    .llc_evt_o     ( llc_evt     )
  );

  l2_bank_mem i_l2_bank_mem (
    .clk_i   ( clk_i    ),
    .rst_n_i ( rst_n_i  ),
    .req_i   ( l2_req   ),
    .rdata_o ( l2_rdata )
  );

  cfg_regs #(
    .CntWidth ( CntWidth )
  ) i_cfg_regs (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .req_i            ( cfg_req          ),
    .rdata_o          ( cfg_rdata        ),
    .llc_evt_i        ( llc_evt          ),
    .dma_evt_i        ( dma_evt          ),
    .cache_start_o    ( cache_start      ),
    .cache_end_o      ( cache_end        ),
    .doorbell_irq_o   ( doorbell_irq_o   ),
    .completion_irq_o ( completion_irq_o )
  );

  // DMA PE events come from the cluster clock domain
  edge_propagator_rx i_edge_propagator_rx (
    .clk_i   ( clk_i              ),
    .rst_n_i ( rst_n_i            ),
    .valid_i ( dma_pe_evt_valid_i ),
    .valid_o ( dma_evt            ),
    .ack_o   ( dma_pe_evt_ack_o   )
  );

endmodule

//--- sim/tb_host_domain.sv
//####################
// Host domain testbench
// Directed tests over L2, config registers and DMA events
//####################

`timescale 1ns/100ps

module tb_host_domain;

  localparam int unsigned NbDmaToggles = 6;
  localparam int unsigned WaitLimit    = 10;

  logic                       clk;
  logic                       rst_n;
  host_domain_pkg::host_req_t host_req;
  host_domain_pkg::host_rsp_t host_rsp;
  logic                       dma_valid;
  logic                       dma_ack;
  logic                       doorbell_irq;
  logic                       completion_irq;

  int seed;
  int errors;
  int tests_run;
  int tests_failed;

  host_domain #(
    .CntWidth ( 32 )
  ) dut (
    .clk_i              ( clk            ),
    .rst_n_i            ( rst_n          ),
    .host_req_i         ( host_req       ),
    .host_rsp_o         ( host_rsp       ),
    .dma_pe_evt_valid_i ( dma_valid      ),
    .dma_pe_evt_ack_o   ( dma_ack        ),
    .doorbell_irq_o     ( doorbell_irq   ),
    .completion_irq_o   ( completion_irq )
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("[FAIL] %s %s: expected %h, actual %h", test, what, exp, act);
    errors++;
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d checks failed", name, errors - errs_before);
    end
  endtask

  // One request, then wait for its response
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int cnt;
    cnt = 0;
    @(posedge clk);
    host_req <= '{req: 1'b1, we: we, addr: addr, wdata: wdata};
    @(negedge clk);
    if (host_rsp.rvalid !== 1'b0) begin
      $display("ERROR: response valid with no request pending, before address %h", addr);
      errors++;
    end
    @(posedge clk);
    host_req <= '0;
    do begin
      @(negedge clk);
      cnt++;
    end while (host_rsp.rvalid !== 1'b1 && cnt < WaitLimit);
    if (host_rsp.rvalid !== 1'b1) begin
      abort_run($sformatf("no response for access to address %h", addr));
    end else begin
      if (cnt != 1) begin
        $display("ERROR: response to address %h came after %0d cycles", addr, cnt);
        errors++;
      end
      rdata = host_rsp.rdata;
      err   = host_rsp.err;
    end
  endtask

  task automatic wait_ack(input logic level);
    int cnt;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (dma_ack !== level && cnt < WaitLimit);
    if (dma_ack !== level) begin
      abort_run("DMA event acknowledge did not follow the valid level");
    end
  endtask

  task automatic reset_state();
    logic [31:0] rdata;
    logic        err;
    int          errs0;
    int          off;
    errs0 = errors;
    if (doorbell_irq !== 1'b0) report_mismatch("reset_state", "doorbell_irq", 0, doorbell_irq);
    if (completion_irq !== 1'b0) begin
      report_mismatch("reset_state", "completion_irq", 0, completion_irq);
    end
    if (dma_ack !== 1'b0) report_mismatch("reset_state", "dma_ack", 0, dma_ack);
    for (off = 0; off <= 32'h20; off += 4) begin
      bus_access(1'b0, host_domain_pkg::CfgBase + off, '0, rdata, err);
      if (rdata !== 32'h0) report_mismatch("reset_state", $sformatf("reg %h", off), 0, rdata);
      if (err !== 1'b0) report_mismatch("reset_state", "err", 0, err);
    end
    end_test("reset_state", errs0);
  endtask

  // Last 16 words of L2 span every bank and the top row
  task automatic l2_data_readback();
    logic [31:0] exp_mem [16];
    logic [31:0] base;
    logic [31:0] rdata;
    logic        err;
    int          errs0;
    int          i;
    errs0 = errors;
    base  = host_domain_pkg::L2Base + host_domain_pkg::L2Size - 64;
    for (i = 0; i < 16; i++) begin
      exp_mem[i] = $random(seed);
      bus_access(1'b1, base + 4 * i, exp_mem[i], rdata, err);
    end
    for (i = 0; i < 16; i++) begin
      bus_access(1'b0, base + 4 * i, '0, rdata, err);
      if (rdata !== exp_mem[i]) report_mismatch("l2_data", $sformatf("word %0d", i),
                                                exp_mem[i], rdata);
      if (err !== 1'b0) report_mismatch("l2_data", "err", 0, err);
    end
    end_test("l2_data", errs0);
  endtask

  task automatic access_classification();
    logic [31:0] win_start;
    logic [31:0] win_end;
    logic [31:0] word;
    logic [31:0] addr;
    logic [31:0] rdata;
    logic        err;
    logic        we;
    logic        cached;
    int          exp_cnt [4];
    int          errs0;
    int          i;
    errs0     = errors;
    win_start = host_domain_pkg::L2Base;
    win_end   = host_domain_pkg::L2Base + host_domain_pkg::L2Size / 2;
    bus_access(1'b1, host_domain_pkg::CfgBase + host_domain_pkg::RegCacheStart, win_start,
               rdata, err);
    bus_access(1'b1, host_domain_pkg::CfgBase + host_domain_pkg::RegCacheEnd, win_end,
               rdata, err);
    for (i = 0; i < 4; i++) begin
      bus_access(1'b1, host_domain_pkg::CfgBase + host_domain_pkg::RegCachedRd + 4 * i, '0,
                 rdata, err);
      exp_cnt[i] = 0;
    end
    for (i = 0; i < 24; i++) begin
      word = $random(seed);
      addr = host_domain_pkg::L2Base + {word[12:0], 2'b00};
      // Window edges first
      if (i == 0) addr = win_end - 4;
      if (i == 1) addr = win_end;
      we     = word[20];
      cached = (addr >= win_start) && (addr < win_end);
      exp_cnt[{!cached, we}]++;
      bus_access(we, addr, word, rdata, err);
    end
    for (i = 0; i < 4; i++) begin
      bus_access(1'b0, host_domain_pkg::CfgBase + host_domain_pkg::RegCachedRd + 4 * i, '0,
                 rdata, err);
      if (rdata !== exp_cnt[i]) report_mismatch("classification", $sformatf("counter %0d", i),
                                                exp_cnt[i], rdata);
    end
    bus_access(1'b1, host_domain_pkg::CfgBase + host_domain_pkg::RegUncachedRd, 32'hFFFF_FFFF,
               rdata, err);
    bus_access(1'b0, host_domain_pkg::CfgBase + host_domain_pkg::RegUncachedRd, '0, rdata, err);
    if (rdata !== 32'h0) report_mismatch("classification", "cleared counter", 0, rdata);
    end_test("classification", errs0);
  endtask

  task automatic unmapped_access();
    logic [31:0] bad_addr [3];
    logic [31:0] snap [4];
    logic [31:0] rdata;
    logic        err;
    int          errs0;
    int          i;
    errs0       = errors;
    bad_addr[0] = 32'h0000_0100;
    bad_addr[1] = host_domain_pkg::L2Base + host_domain_pkg::L2Size;
    bad_addr[2] = host_domain_pkg::CfgBase + host_domain_pkg::CfgSize;
    bus_access(1'b1, host_domain_pkg::L2Base, 32'h5A5A_0001, rdata, err);
    for (i = 0; i < 4; i++) begin
      bus_access(1'b0, host_domain_pkg::CfgBase + host_domain_pkg::RegCachedRd + 4 * i, '0,
                 snap[i], err);
    end
    for (i = 0; i < 3; i++) begin
      bus_access(1'b0, bad_addr[i], '0, rdata, err);
      if (err !== 1'b1) report_mismatch("unmapped", "read err", 1, err);
      if (rdata !== host_domain_pkg::ErrData) begin
        report_mismatch("unmapped", "read data", host_domain_pkg::ErrData, rdata);
      end
      bus_access(1'b1, bad_addr[i], 32'h1234_5678, rdata, err);
      if (err !== 1'b1) report_mismatch("unmapped", "write err", 1, err);
      if (rdata !== 32'h0) report_mismatch("unmapped", "write data", 0, rdata);
    end
    for (i = 0; i < 4; i++) begin
      bus_access(1'b0, host_domain_pkg::CfgBase + host_domain_pkg::RegCachedRd + 4 * i, '0,
                 rdata, err);
      if (rdata !== snap[i]) report_mismatch("unmapped", $sformatf("counter %0d", i),
                                             snap[i], rdata);
    end
    bus_access(1'b0, host_domain_pkg::L2Base, '0, rdata, err);
    if (rdata !== 32'h5A5A_0001) report_mismatch("unmapped", "L2 word", 32'h5A5A_0001, rdata);
    end_test("unmapped", errs0);
  endtask

  task automatic irq_set_clear();
    logic [31:0] rdata;
    logic        err;
    int          errs0;
    errs0 = errors;
    bus_access(1'b1, host_domain_pkg::CfgBase + host_domain_pkg::RegDoorbell, 1, rdata, err);
    if (doorbell_irq !== 1'b1) report_mismatch("interrupts", "doorbell set", 1, doorbell_irq);
    if (completion_irq !== 1'b0) report_mismatch("interrupts", "completion", 0, completion_irq);
    bus_access(1'b1, host_domain_pkg::CfgBase + host_domain_pkg::RegDoorbell, 0, rdata, err);
    if (doorbell_irq !== 1'b0) report_mismatch("interrupts", "doorbell clr", 0, doorbell_irq);
    bus_access(1'b1, host_domain_pkg::CfgBase + host_domain_pkg::RegCompletion, 1, rdata, err);
    if (completion_irq !== 1'b1) begin
      report_mismatch("interrupts", "completion set", 1, completion_irq);
    end
    if (doorbell_irq !== 1'b0) report_mismatch("interrupts", "doorbell", 0, doorbell_irq);
    bus_access(1'b1, host_domain_pkg::CfgBase + host_domain_pkg::RegCompletion, 0, rdata, err);
    if (completion_irq !== 1'b0) begin
      report_mismatch("interrupts", "completion clr", 0, completion_irq);
    end
    end_test("interrupts", errs0);
  endtask

  task automatic dma_event_count();
    logic [31:0] rdata;
    logic        err;
    logic        level;
    int          errs0;
    int          i;
    errs0 = errors;
    for (i = 0; i < NbDmaToggles; i++) begin
      @(posedge clk);
      level = !dma_valid;
      dma_valid <= level;
      wait_ack(level);
      @(posedge clk);
    end
    bus_access(1'b0, host_domain_pkg::CfgBase + host_domain_pkg::RegDmaEvt, '0, rdata, err);
    if (rdata !== NbDmaToggles) report_mismatch("dma_events", "event count", NbDmaToggles, rdata);
    end_test("dma_events", errs0);
  endtask

  initial begin
    seed         = 32'h4de6;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    clk          = 1'b0;
    rst_n        = 1'b0;
    host_req     = '0;
    dma_valid    = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    reset_state();
    l2_data_readback();
    access_classification();
    unmapped_access();
    irq_set_clear();
    dma_event_count();
    $display("%0d tests run, %0d failed, %0d checks failed", tests_run, tests_failed, errors);
    if (tests_failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- host_domain.f
design/host_domain_pkg.sv
design/edge_propagator_rx.sv
design/l2_bank_mem.sv
design/cfg_regs.sv
design/host_bus_decode.sv
design/host_domain.sv
sim/tb_host_domain.sv

//--- Bender.yml
package:
  name: host_domain

sources:
  - files:
      - design/host_domain_pkg.sv
      - design/edge_propagator_rx.sv
      - design/l2_bank_mem.sv
      - design/cfg_regs.sv
      - design/host_bus_decode.sv
      - design/host_domain.sv
  - target: simulation
    files:
      - sim/tb_host_domain.sv
